// ==== cmd_bridge_top.f ====
logic/cmd_bridge_pkg.sv
logic/reg_bus_if.sv
logic/cmd_frame_parser.sv
logic/cmd_bus_master.sv
logic/fifo_status_regs.sv
logic/scratch_mem.sv
logic/resp_frame_builder.sv
logic/cmd_bridge_top.sv
bench/cmd_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the command bridge testbench with Verilator, run it, and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module cmd_bridge_tb -f cmd_bridge_top.f -o cmd_bridge_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/cmd_bridge_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q -F '** FAIL **' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

exit 0

// ==== bench/cmd_bridge_tb.sv ====
`timescale 1ns/1ps

module cmd_bridge_tb;

    localparam logic [7:0]  OP_WR     = 8'h01;
    localparam logic [7:0]  OP_RD     = 8'h02;
    localparam logic [31:0] STAT_ADDR = 32'h1000_0000;
    localparam logic [31:0] FIFO_ADDR = 32'h1000_0002;
    localparam logic [1:0]  RSP_OK    = 2'd0;
    localparam logic [1:0]  RSP_ERR   = 2'd2;
    localparam logic [1:0]  RSP_BAD   = 2'd3;
    localparam int          DEPTH     = 4;
    localparam int          WORDS     = 256;
    localparam int          N_ROWS    = 19;
    localparam int          WAIT_MAX  = 200; // cycles per wait loop

    typedef struct packed {
        logic [7:0]  op;
        logic [7:0]  len;   // beats minus one
        logic        incr;
        logic [31:0] addr;
        logic        trunc; // frame cut after the first data word
        logic        ones;  // all-ones write data
        logic [1:0]  resp;
        logic        chk;   // compare read words with the model
    } row_t;

    logic       external_clk;
    logic       rst;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_last;
    logic       rx_busy;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_last;

    row_t        rows [N_ROWS];
    logic [31:0] mem_model [WORDS];
    logic [31:0] fifo_model [$];
    logic [7:0]  frame [$];
    logic [7:0]  expect_q [$];
    logic [7:0]  got_q [$];
    integer      seed;
    int          errors;
    int          failed_tests;
    int          run_tests;
    logic        aborted;
    int          i;

    always #20 external_clk = ~external_clk;

    cmd_bridge_top #(
        .FIFO_DEPTH ( DEPTH ),
        .MEM_WORDS  ( WORDS )
    ) dut_i (
        .external_clk ( external_clk ),
        .rst          ( rst          ),
        .rx_valid     ( rx_valid     ),
        .rx_data      ( rx_data      ),
        .rx_last      ( rx_last      ),
        .rx_busy      ( rx_busy      ),
        .tx_valid     ( tx_valid     ),
        .tx_data      ( tx_data      ),
        .tx_last      ( tx_last      )
    );

    //////////////////////////////////////////////////////////////////////
    // command table
    //////////////////////////////////////////////////////////////////////
    task automatic load_table();
        rows[0]  = '{OP_RD, 8'd0, 1'b0, STAT_ADDR, 1'b0, 1'b0, RSP_OK, 1'b1};  // status after reset
        rows[1]  = '{OP_WR, 8'd3, 1'b0, FIFO_ADDR, 1'b0, 1'b0, RSP_OK, 1'b0};  // fill the FIFO
        rows[2]  = '{OP_RD, 8'd0, 1'b0, STAT_ADDR, 1'b0, 1'b0, RSP_OK, 1'b1};  // full
        rows[3]  = '{OP_WR, 8'd0, 1'b0, FIFO_ADDR, 1'b0, 1'b0, RSP_ERR, 1'b0}; // push when full
        rows[4]  = '{OP_WR, 8'd0, 1'b0, STAT_ADDR, 1'b0, 1'b1, RSP_OK, 1'b0};  // clear
        rows[5]  = '{OP_RD, 8'd0, 1'b0, STAT_ADDR, 1'b0, 1'b0, RSP_OK, 1'b1};
        rows[6]  = '{OP_WR, 8'd2, 1'b0, FIFO_ADDR, 1'b0, 1'b0, RSP_OK, 1'b0};
        rows[7]  = '{OP_RD, 8'd2, 1'b0, FIFO_ADDR, 1'b0, 1'b0, RSP_OK, 1'b1};  // fifo order
        rows[8]  = '{OP_WR, 8'd5, 1'b1, 32'h10, 1'b0, 1'b0, RSP_OK, 1'b0};
        rows[9]  = '{OP_RD, 8'd5, 1'b1, 32'h10, 1'b0, 1'b0, RSP_OK, 1'b1};
        rows[10] = '{OP_WR, 8'd3, 1'b0, 32'h40, 1'b0, 1'b0, RSP_OK, 1'b0};     // fixed burst
        rows[11] = '{OP_RD, 8'd0, 1'b0, 32'h40, 1'b0, 1'b0, RSP_OK, 1'b1};
        rows[12] = '{OP_WR, 8'd0, 1'b0, FIFO_ADDR, 1'b0, 1'b0, RSP_OK, 1'b0};
        rows[13] = '{OP_RD, 8'd2, 1'b1, FIFO_ADDR, 1'b0, 1'b0, RSP_ERR, 1'b1}; // runs off the map
        rows[14] = '{OP_WR, 8'd1, 1'b1, 32'h10, 1'b1, 1'b0, RSP_BAD, 1'b0};    // early end
        rows[15] = '{8'h07, 8'd0, 1'b0, 32'h10, 1'b0, 1'b0, RSP_BAD, 1'b0};    // unknown opcode
        rows[16] = '{OP_RD, 8'd5, 1'b1, 32'h10, 1'b0, 1'b0, RSP_OK, 1'b1};
        rows[17] = '{OP_RD, 8'd0, 1'b0, STAT_ADDR, 1'b0, 1'b0, RSP_OK, 1'b1};
        rows[18] = '{OP_RD, 8'd0, 1'b0, 32'h100, 1'b0, 1'b0, RSP_ERR, 1'b1};   // past memory end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model of the two slaves
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] status_word();
        logic [7:0] cnt;
        cnt = 8'(fifo_model.size());
        return {8'h01, 8'(DEPTH), cnt, 6'd0, cnt == 8'(DEPTH), cnt == 8'd0};
    endfunction

    task automatic model_beat(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        rdata = 32'd0; // unmapped and failed beats read zero
        if (addr == STAT_ADDR) begin
            if (wr && wdata == 32'hFFFF_FFFF) begin
                fifo_model.delete();
            end else if (!wr) begin
                rdata = status_word();
            end
        end else if (addr == FIFO_ADDR) begin
            if (wr && fifo_model.size() < DEPTH) begin
                fifo_model.push_back(wdata);
            end else if (!wr && fifo_model.size() > 0) begin
                rdata = fifo_model.pop_front();
            end
        end else if (addr[31:8] == 24'd0 && addr < 32'(WORDS)) begin
            if (wr) begin
                mem_model[addr[7:0]] = wdata;
            end else begin
                rdata = mem_model[addr[7:0]];
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // frame traffic
    //////////////////////////////////////////////////////////////////////
    task automatic send_bytes();
        int n;
        for (n = 0; n < frame.size(); n++) begin
            @(negedge external_clk);
            rx_valid = 1'b1;
            rx_data  = frame[n];
            rx_last  = (n == frame.size() - 1);
        end
        @(negedge external_clk);
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        rx_data  = 8'h00;
    endtask

    task automatic wait_idle(output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < WAIT_MAX && !ok; n++) begin
            @(negedge external_clk);
            ok = !rx_busy;
        end
    endtask

    task automatic collect_resp(output logic ok);
        int n;
        got_q.delete();
        ok = 1'b0;
        for (n = 0; n < WAIT_MAX && !ok; n++) begin
            @(negedge external_clk);
            if (tx_valid) begin
                got_q.push_back(tx_data);
                ok = tx_last; // frame complete
            end
        end
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [31:0] wd [8];
        logic [31:0] rd [8];
        logic [31:0] a;
        int          beats;
        int          errs_before;
        int          b;
        int          k;
        logic        ok;
        r           = rows[idx];
        beats       = int'(r.len[2:0]) + 1;
        errs_before = errors;
        a           = r.addr;
        run_tests++;
        frame.delete();
        frame.push_back(r.op);
        frame.push_back(r.len);
        frame.push_back({7'd0, r.incr});
        for (k = 3; k >= 0; k--) begin
            frame.push_back(r.addr[8*k +: 8]); // msb first
        end
        for (b = 0; b < beats; b++) begin
            wd[b] = r.ones ? 32'hFFFF_FFFF : $random(seed);
            if (r.op == OP_WR) begin
                for (k = 3; k >= 0; k--) begin
                    frame.push_back(wd[b][8*k +: 8]);
                end
            end
        end
        while (r.trunc && frame.size() > 11) begin
            void'(frame.pop_back());
        end
        expect_q.delete();
        expect_q.push_back(r.op);
        expect_q.push_back({6'd0, r.resp});
        if (r.resp != RSP_BAD) begin // malformed frames leave the slaves alone
            for (b = 0; b < beats; b++) begin
                model_beat(r.op == OP_WR, a, wd[b], rd[b]);
                if (r.incr) begin
                    a = a + 32'd1;
                end
                if (r.op == OP_RD) begin
                    for (k = 3; k >= 0; k--) begin
                        expect_q.push_back(rd[b][8*k +: 8]);
                    end
                end
            end
        end
        wait_idle(ok);
        if (!ok) begin
            $display("timeout: rx_busy stayed high before test %0d", idx);
            errors++;
            failed_tests++;
            aborted = 1'b1;
            return;
        end
        send_bytes();
        collect_resp(ok);
        if (!ok) begin
            $display("timeout: no complete response frame for test %0d", idx);
            errors++;
            failed_tests++;
            aborted = 1'b1;
            return;
        end
        if (got_q.size() != expect_q.size()) begin
            $display("CHECK FAILED at %0t: test %0d response has %0d bytes, expected %0d",
                     $time, idx, got_q.size(), expect_q.size());
            errors++;
        end else begin
            for (b = 0; b < expect_q.size(); b++) begin
                if ((b < 2 || r.chk) && got_q[b] !== expect_q[b]) begin
                    $display("CHECK FAILED at %0t: test %0d byte %0d is %02h, expected %02h",
                             $time, idx, b, got_q[b], expect_q[b]);
                    errors++;
                end
            end
        end
        if (errors == errs_before) begin
            $display("test %0d op %02h addr %08h: passed", idx, r.op, r.addr);
        end else begin
            failed_tests++;
            $display("test %0d op %02h addr %08h: failed", idx, r.op, r.addr);
        end
    endtask

    initial begin
        external_clk = 1'b0;
        rst          = 1'b1;
        rx_valid     = 1'b0;
        rx_data      = 8'h00;
        rx_last      = 1'b0;
        seed         = 32'h2bf0f703;
        errors       = 0;
        failed_tests = 0;
        run_tests    = 0;
        aborted      = 1'b0;
        load_table();
        repeat (10) @(negedge external_clk);
        rst = 1'b0;
        for (i = 0; i < N_ROWS && !aborted; i++) begin
            run_row(i);
        end
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 run_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== logic/cmd_bridge_top.sv ====
`timescale 1ns/1ps

module cmd_bridge_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int MEM_WORDS  = 256
) (
    input  logic       external_clk,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    input  logic       rx_last,
    output logic       rx_busy,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    output logic       tx_last
);

    logic                    cmd_valid;
    cmd_bridge_pkg::opcode_t cmd_op;
    cmd_bridge_pkg::len_t    cmd_len;
    logic                    cmd_incr;
    cmd_bridge_pkg::addr_t   cmd_addr;
    cmd_bridge_pkg::word_t   cmd_wdata [cmd_bridge_pkg::MAX_BEATS];
    logic                    cmd_malformed;
    logic                    res_valid;
    cmd_bridge_pkg::resp_t   res_resp;
    cmd_bridge_pkg::word_t   res_rdata [cmd_bridge_pkg::MAX_BEATS];

    reg_bus_if reg_bus ();  // status and FIFO slave
    reg_bus_if mem_bus ();  // scratch memory slave

    cmd_frame_parser u_parser (
        .external_clk  ( external_clk  ),
        .rst           ( rst           ),
        .rx_valid      ( rx_valid      ),
        .rx_data       ( rx_data       ),
        .rx_last       ( rx_last       ),
        .busy_clear    ( tx_last       ),
        .rx_busy       ( rx_busy       ),
        .cmd_valid     ( cmd_valid     ),
        .cmd_op        ( cmd_op        ),
        .cmd_len       ( cmd_len       ),
        .cmd_incr      ( cmd_incr      ),
        .cmd_addr      ( cmd_addr      ),
        .cmd_wdata     ( cmd_wdata     ),
        .cmd_malformed ( cmd_malformed )
    );

    cmd_bus_master #(
        .MEM_WORDS ( MEM_WORDS )
    ) u_master (
        .external_clk  ( external_clk  ),
        .rst           ( rst           ),
        .cmd_valid     ( cmd_valid     ),
        .cmd_op        ( cmd_op        ),
        .cmd_len       ( cmd_len       ),
        .cmd_incr      ( cmd_incr      ),
        .cmd_addr      ( cmd_addr      ),
        .cmd_wdata     ( cmd_wdata     ),
        .cmd_malformed ( cmd_malformed ),
        .reg_bus       ( reg_bus       ),
        .mem_bus       ( mem_bus       ),
        .res_valid     ( res_valid     ),
        .res_resp      ( res_resp      ),
        .res_rdata     ( res_rdata     )
    );

    fifo_status_regs #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_regs (
        .external_clk ( external_clk ),
        .rst          ( rst          ),
        .bus          ( reg_bus      )
    );

    scratch_mem #(
        .MEM_WORDS ( MEM_WORDS )
    ) u_mem (
        .external_clk ( external_clk ),
        .rst          ( rst          ),
        .bus          ( mem_bus      )
    );

    resp_frame_builder u_builder (
        .external_clk ( external_clk ),
        .rst          ( rst          ),
        .res_valid    ( res_valid    ),
        .res_op       ( cmd_op       ),
        .res_len      ( cmd_len      ),
        .res_resp     ( res_resp     ),
        .res_rdata    ( res_rdata    ),
        .tx_valid     ( tx_valid     ),
        .tx_data      ( tx_data      ),
        .tx_last      ( tx_last      )
    );

endmodule

// ==== logic/resp_frame_builder.sv ====
`timescale 1ns/1ps

module resp_frame_builder (
    input  logic                    external_clk,
    input  logic                    rst,
    input  logic                    res_valid,
    input  cmd_bridge_pkg::opcode_t res_op,
    input  cmd_bridge_pkg::len_t    res_len,
    input  cmd_bridge_pkg::resp_t   res_resp,
    input  cmd_bridge_pkg::word_t   res_rdata [cmd_bridge_pkg::MAX_BEATS],
    output logic                    tx_valid,
    output logic [7:0]              tx_data,
    output logic                    tx_last
);

    cmd_bridge_pkg::resp_t resp_q;
    cmd_bridge_pkg::word_t rdata_q [cmd_bridge_pkg::MAX_BEATS];
    logic [5:0]            last_q;    // index of the final byte
    logic [5:0]            cnt;       // index of the next byte
    logic [5:0]            k;
    logic [7:0]            next_byte;

    // byte 0 opcode, byte 1 response, then read words msb first
    assign k         = cnt - 6'd2;
    assign next_byte = (cnt == 6'd1) ? {6'd0, resp_q} :
                       rdata_q[k[4:2]][{~k[1:0], 3'b000} +: 8];

    always_ff @(posedge external_clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
            cnt      <= '0;
        end else if (res_valid) begin
            tx_valid <= 1'b1;
            tx_last  <= 1'b0;
            cnt      <= 6'd1;
        end else if (tx_valid && !tx_last) begin
            tx_last <= (cnt == last_q);
            cnt     <= cnt + 6'd1;
        end else begin
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
        end
    end

    always_ff @(posedge external_clk) begin
        if (res_valid) begin
            tx_data <= res_op; // echo
            resp_q  <= res_resp;
            rdata_q <= res_rdata;
            if (res_op == cmd_bridge_pkg::OP_READ &&
                res_resp != cmd_bridge_pkg::RESP_MALFORMED) begin
                last_q <= 6'd5 + {1'b0, res_len, 2'b00};
            end else begin
                last_q <= 6'd1; // header only
            end
        end else if (tx_valid && !tx_last) begin
            tx_data <= next_byte;
        end
    end

endmodule

// ==== logic/scratch_mem.sv ====
`timescale 1ns/1ps

module scratch_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic     external_clk,
    input  logic     rst,
    reg_bus_if.slave bus
);

    localparam int AW = $clog2(MEM_WORDS);

    cmd_bridge_pkg::word_t mem [MEM_WORDS];
    logic [AW-1:0]         idx;

    assign idx      = bus.addr[AW-1:0]; // range checked by the master
    assign bus.resp = cmd_bridge_pkg::RESP_OKAY;

    always_ff @(posedge external_clk) begin
        if (rst) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.req;
        end
    end

    always_ff @(posedge external_clk) begin
        if (bus.req) begin
            if (bus.we) begin
                mem[idx] <= bus.wdata;
            end else begin
                bus.rdata <= mem[idx];
            end
        end
    end

endmodule

// ==== logic/fifo_status_regs.sv ====
`timescale 1ns/1ps

module fifo_status_regs #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     external_clk,
    input  logic     rst,
    reg_bus_if.slave bus
);

    localparam int PW = $clog2(FIFO_DEPTH);

    cmd_bridge_pkg::word_t fifo_mem [FIFO_DEPTH];
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [PW:0]           count;
    logic                  full;
    logic                  empty;
    logic                  is_fifo;
    logic                  push;
    logic                  pop;
    logic                  clr;
    cmd_bridge_pkg::word_t status;

    assign full    = (count == (PW + 1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign is_fifo = (bus.addr == cmd_bridge_pkg::REG_FIFO); // else status
    assign push    = bus.req && bus.we && is_fifo && !full;
    assign pop     = bus.req && !bus.we && is_fifo && !empty;
    assign clr     = bus.req && bus.we && !is_fifo && (bus.wdata == '1);
    assign status  = {8'h01, 8'(FIFO_DEPTH), 8'(count), 6'd0, full, empty};

    always_ff @(posedge external_clk) begin
        if (rst) begin
            bus.done <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
        end else begin
            bus.done <= bus.req;
            if (clr) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // power-of-two wrap
                count  <= count + 1'b1;
            end else if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                count  <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge external_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= bus.wdata;
        end
        if (bus.req) begin
            bus.rdata <= '0;
            bus.resp  <= cmd_bridge_pkg::RESP_OKAY;
            if (is_fifo) begin
                if (bus.we ? full : empty) begin
                    bus.resp <= cmd_bridge_pkg::RESP_SLVERR;
                end else if (!bus.we) begin
                    bus.rdata <= fifo_mem[rd_ptr]; // pop head
                end
            end else if (!bus.we) begin
                bus.rdata <= status;
            end
        end
    end

    a_count: assert property (@(posedge external_clk) disable iff (rst)
        count <= (PW + 1)'(FIFO_DEPTH));

endmodule

// ==== logic/cmd_bus_master.sv ====
`timescale 1ns/1ps

module cmd_bus_master #(
    parameter int MEM_WORDS = 256
) (
    input  logic                    external_clk,
    input  logic                    rst,
    input  logic                    cmd_valid,
    input  cmd_bridge_pkg::opcode_t cmd_op,
    input  cmd_bridge_pkg::len_t    cmd_len,
    input  logic                    cmd_incr,
    input  cmd_bridge_pkg::addr_t   cmd_addr,
    input  cmd_bridge_pkg::word_t   cmd_wdata [cmd_bridge_pkg::MAX_BEATS],
    input  logic                    cmd_malformed,
    reg_bus_if.master               reg_bus,
    reg_bus_if.master               mem_bus,
    output logic                    res_valid,
    output cmd_bridge_pkg::resp_t   res_resp,
    output cmd_bridge_pkg::word_t   res_rdata [cmd_bridge_pkg::MAX_BEATS]
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_ACK} state_t;

    state_t                state;
    cmd_bridge_pkg::len_t  beat;
    cmd_bridge_pkg::addr_t cur_addr;
    logic                  hit_reg;
    logic                  hit_mem;
    cmd_bridge_pkg::word_t beat_data;
    cmd_bridge_pkg::resp_t beat_resp;

    // per-beat decode
    assign hit_reg = (cur_addr == cmd_bridge_pkg::REG_BASE) ||
                     (cur_addr == cmd_bridge_pkg::REG_FIFO);
    assign hit_mem = ((cur_addr & cmd_bridge_pkg::MEM_REGION_MASK) == '0) &&
                     (cur_addr < cmd_bridge_pkg::addr_t'(MEM_WORDS));

    assign reg_bus.req   = (state == ST_REQ) && hit_reg;
    assign mem_bus.req   = (state == ST_REQ) && hit_mem;
    assign reg_bus.we    = (cmd_op == cmd_bridge_pkg::OP_WRITE);
    assign mem_bus.we    = (cmd_op == cmd_bridge_pkg::OP_WRITE);
    assign reg_bus.addr  = cur_addr;
    assign mem_bus.addr  = cur_addr;
    assign reg_bus.wdata = cmd_wdata[beat];
    assign mem_bus.wdata = cmd_wdata[beat];

    // unmapped beat reads as zero with SLVERR
    assign beat_data = hit_reg ? reg_bus.rdata : (hit_mem ? mem_bus.rdata : '0);
    assign beat_resp = hit_reg ? reg_bus.resp :
                       (hit_mem ? mem_bus.resp : cmd_bridge_pkg::RESP_SLVERR);

    always_ff @(posedge external_clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        res_resp <= cmd_malformed ? cmd_bridge_pkg::RESP_MALFORMED :
                                                    cmd_bridge_pkg::RESP_OKAY;
                        if (cmd_malformed) begin
                            res_valid <= 1'b1; // no bus traffic
                        end else begin
                            state    <= ST_REQ;
                            cur_addr <= cmd_addr;
                            beat     <= '0;
                        end
                    end
                end
                ST_REQ: state <= ST_ACK;
                ST_ACK: begin
                    res_rdata[beat] <= beat_data;
                    if (beat_resp > res_resp) begin
                        res_resp <= beat_resp; // worst code wins
                    end
                    if (cmd_incr) begin
                        cur_addr <= cur_addr + 32'd1;
                    end
                    if (beat == cmd_len) begin
                        state     <= ST_IDLE;
                        res_valid <= 1'b1;
                    end else begin
                        beat  <= beat + 1'b1;
                        state <= ST_REQ;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_one_port: assert property (@(posedge external_clk) disable iff (rst)
        !(reg_bus.req && mem_bus.req));
    a_reg_done: assert property (@(posedge external_clk) disable iff (rst)
        reg_bus.done |-> $past(reg_bus.req));
    a_mem_done: assert property (@(posedge external_clk) disable iff (rst)
        mem_bus.done |-> $past(mem_bus.req));

endmodule

// ==== logic/cmd_frame_parser.sv ====
`timescale 1ns/1ps

module cmd_frame_parser (
    input  logic                    external_clk,
    input  logic                    rst,
    input  logic                    rx_valid,
    input  logic [7:0]              rx_data,
    input  logic                    rx_last,
    input  logic                    busy_clear,
    output logic                    rx_busy,
    output logic                    cmd_valid,
    output cmd_bridge_pkg::opcode_t cmd_op,
    output cmd_bridge_pkg::len_t    cmd_len,
    output logic                    cmd_incr,
    output cmd_bridge_pkg::addr_t   cmd_addr,
    output cmd_bridge_pkg::word_t   cmd_wdata [cmd_bridge_pkg::MAX_BEATS],
    output logic                    cmd_malformed
);

    typedef enum logic [1:0] {ST_HDR, ST_ADDR, ST_DATA, ST_WAIT} state_t;

    state_t     state;
    logic [5:0] byte_cnt;   // index of the byte now on rx_data
    logic [5:0] data_idx;
    logic [5:0] last_idx;   // expected index of the final byte
    logic       op_known;
    logic       final_hit;
    logic       frame_end;
    logic       cmd_seen;

    assign data_idx  = byte_cnt - 6'd7;
    assign op_known  = (cmd_op == cmd_bridge_pkg::OP_WRITE) ||
                       (cmd_op == cmd_bridge_pkg::OP_READ);
    assign last_idx  = (cmd_op == cmd_bridge_pkg::OP_WRITE) ?
                       6'd10 + {1'b0, cmd_len, 2'b00} : 6'd6;
    assign final_hit = op_known && (byte_cnt == last_idx);
    assign frame_end = rx_last || final_hit; // unknown opcode drains until rx_last

    always_ff @(posedge external_clk) begin
        if (rst) begin
            state     <= ST_HDR;
            byte_cnt  <= '0;
            rx_busy   <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (state == ST_WAIT) begin
                if (busy_clear) begin // response sent
                    state    <= ST_HDR;
                    byte_cnt <= '0;
                    rx_busy  <= 1'b0;
                end
            end else if (rx_valid) begin
                rx_busy  <= 1'b1;
                byte_cnt <= byte_cnt + 6'd1;
                if (frame_end) begin
                    cmd_valid <= 1'b1;
                    state     <= ST_WAIT;
                end else if (state == ST_HDR && byte_cnt == 6'd2) begin
                    state <= ST_ADDR;
                end else if (state == ST_ADDR && byte_cnt == 6'd6) begin
                    state <= ST_DATA;
                end
            end
        end
    end

    // command fields, held until the next frame
    always_ff @(posedge external_clk) begin
        if (rx_valid && state != ST_WAIT) begin
            case (state)
                ST_HDR: begin
                    case (byte_cnt[1:0])
                        2'd0:    cmd_op   <= rx_data;
                        2'd1:    cmd_len  <= rx_data[2:0];
                        default: cmd_incr <= rx_data[0];
                    endcase
                end
                ST_ADDR: cmd_addr <= {cmd_addr[23:0], rx_data}; // msb first
                ST_DATA: cmd_wdata[data_idx[4:2]] <= {cmd_wdata[data_idx[4:2]][23:0], rx_data};
                default: ;
            endcase
            if (frame_end) begin
                cmd_malformed <= rx_last ^ final_hit; // early last or missing last
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // one command per busy period
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge external_clk) begin
        if (rst) begin
            cmd_seen <= 1'b0;
        end else if (!rx_busy) begin
            cmd_seen <= 1'b0;
        end else if (cmd_valid) begin
            cmd_seen <= 1'b1;
        end
    end

    a_one_cmd: assert property (@(posedge external_clk) disable iff (rst)
        cmd_valid |-> !cmd_seen);

endmodule

// ==== logic/reg_bus_if.sv ====
`timescale 1ns/1ps

// single-beat register bus; done follows req by exactly one cycle
interface reg_bus_if;
    logic                  req;   // one-cycle request
    logic                  we;    // 1 = write
    cmd_bridge_pkg::addr_t addr;
    cmd_bridge_pkg::word_t wdata;
    cmd_bridge_pkg::word_t rdata; // valid with done
    cmd_bridge_pkg::resp_t resp;  // valid with done
    logic                  done;

    modport master (
        output req, we, addr, wdata,
        input  rdata, resp, done
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, resp, done
    );
endinterface

// ==== logic/cmd_bridge_pkg.sv ====
package cmd_bridge_pkg;

    //////////////////////////////////////////////////////////////////////
    // data widths
    //////////////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;   // bus data word
    typedef logic [31:0] addr_t;   // word address
    typedef logic [1:0]  resp_t;   // response code
    typedef logic [7:0]  opcode_t; // command opcode

    localparam int MAX_BEATS = 8;  // longest burst

    typedef logic [$clog2(MAX_BEATS)-1:0] len_t; // beats minus one

    //////////////////////////////////////////////////////////////////////
    // codes
    //////////////////////////////////////////////////////////////////////
    localparam resp_t RESP_OKAY      = 2'd0;
    localparam resp_t RESP_SLVERR    = 2'd2;
    localparam resp_t RESP_MALFORMED = 2'd3;

    localparam opcode_t OP_WRITE = 8'h01;
    localparam opcode_t OP_READ  = 8'h02;

    //////////////////////////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////////////////////////
    localparam addr_t REG_BASE        = 32'h1000_0000; // status register
    localparam addr_t REG_FIFO        = REG_BASE + 32'd2; // shift-in FIFO port
    localparam addr_t MEM_REGION_MASK = 32'hFFFF_FF00; // upper 24 bits must be zero

endpackage
